//--- source/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // rv64 data and address width
    localparam int xlen = 64;
    // one strobe per byte lane
    localparam int mask_w = xlen / 8;
    // architectural register index
    localparam int reg_idx_w = 5;

    // kept rv64i instructions, one code each
    typedef enum logic [5:0] {
        // register/register
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        // register/immediate
        op_addi, op_slti, op_sltiu, op_xori, op_ori,
        op_andi, op_slli, op_srli, op_srai,
        // upper immediates and jumps
        op_lui, op_auipc, op_jal, op_jalr,
        // conditional branches
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        // loads, signed then unsigned
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        // stores
        op_sb, op_sh, op_sw, op_sd,
        op_nop
    } exu_op_e;

    // integer alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_mode_e;

    // execute control states
    typedef enum logic [1:0] {
        st_idle,
        st_mem,
        st_done
    } exu_state_e;

endpackage

`default_nettype wire

//--- source/exu_regfile.sv
`default_nettype none

module exu_regfile #(
    parameter int nregs = 32
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire [exu_pkg::reg_idx_w-1:0] raddr_a,
    input  wire [exu_pkg::reg_idx_w-1:0] raddr_b,
    output logic [exu_pkg::xlen-1:0]     rdata_a,
    output logic [exu_pkg::xlen-1:0]     rdata_b,
    input  wire                          wen,
    input  wire [exu_pkg::reg_idx_w-1:0] waddr,
    input  wire [exu_pkg::xlen-1:0]      wdata
);
    import exu_pkg::*;

    logic [xlen-1:0] regs [nregs];

    // async reads, indices past the array read zero (rv64e)
    assign rdata_a = (raddr_a < nregs) ? regs[raddr_a] : '0;
    assign rdata_b = (raddr_b < nregs) ? regs[raddr_b] : '0;

    // x0 never written so it stays at its reset zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0 && waddr < nregs) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- source/exu_alu.sv
`default_nettype none

module exu_alu (
    input  wire exu_pkg::alu_mode_e     mode,
    input  wire [exu_pkg::xlen-1:0]     a,
    input  wire [exu_pkg::xlen-1:0]     b,
    output logic [exu_pkg::xlen-1:0]    result
);
    import exu_pkg::*;

    // rv64 shift amount is six bits
    logic [5:0] shamt;
    // compare outcomes, widened below
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[5:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (mode)
            alu_add:  result = a + b;
            // beq/bne look for a zero difference
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            // compares give 0 or 1, branches use bit 0
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/exu_lsu.sv
`default_nettype none

module exu_lsu (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         start,
    input  wire exu_pkg::exu_op_e       op,
    input  wire [exu_pkg::xlen-1:0]     addr,
    input  wire [exu_pkg::xlen-1:0]     store_data,
    output logic [exu_pkg::xlen-1:0]    load_data,
    output logic                        lsu_done,
    output logic                        mem_req,
    output logic                        mem_we,
    output logic [exu_pkg::xlen-1:0]    mem_addr,
    output logic [exu_pkg::xlen-1:0]    mem_wdata,
    output logic [exu_pkg::mask_w-1:0]  mem_wmask,
    input  wire [exu_pkg::xlen-1:0]     mem_rdata,
    input  wire                         mem_ack
);
    import exu_pkg::*;

    // byte offset inside the 8-byte word
    logic [2:0]        offset;
    logic              is_store;
    logic [xlen-1:0]   lane_wdata;
    logic [mask_w-1:0] lane_mask;
    // load side, held from start until writeback
    logic [2:0]        offset_q;
    exu_op_e           op_q;
    logic [xlen-1:0]   rdata_q;
    logic [xlen-1:0]   lane_rdata;
    // start seen while the last ack was still high
    logic              pending;

    assign offset     = addr[2:0];
    assign is_store   = op inside {op_sb, op_sh, op_sw, op_sd};
    // store data moved up into its lane
    assign lane_wdata = store_data << {offset, 3'b000};

    always_comb begin
        case (op)
            op_sb:   lane_mask = 8'h01 << offset;
            op_sh:   lane_mask = 8'h03 << offset;
            op_sw:   lane_mask = 8'h0f << offset;
            op_sd:   lane_mask = 8'hff;
            default: lane_mask = '0;
        endcase
    end

    // request payload latched on start, stable while mem_req is up
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr  <= {addr[xlen-1:3], 3'b000};
            mem_wdata <= lane_wdata;
            mem_wmask <= lane_mask;
            offset_q  <= offset;
            op_q      <= op;
        end
        if (mem_req && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    // four-phase req/ack with the memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending  <= 1'b0;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            if (start) begin
                pending <= 1'b1;
                mem_we  <= is_store;
            end
            if (mem_req) begin
                // data taken, drop req and report done together
                if (mem_ack) begin
                    mem_req  <= 1'b0;
                    mem_we   <= 1'b0;
                    lsu_done <= 1'b1;
                end
            end else if ((pending || start) && !mem_ack) begin
                // ack of the previous access has fallen
                mem_req <= 1'b1;
                pending <= 1'b0;
            end
        end
    end

    // lane down to bit 0, then extend by load kind
    assign lane_rdata = rdata_q >> {offset_q, 3'b000};

    always_comb begin
        case (op_q)
            op_lb:   load_data = {{(xlen-8){lane_rdata[7]}}, lane_rdata[7:0]};
            op_lh:   load_data = {{(xlen-16){lane_rdata[15]}}, lane_rdata[15:0]};
            op_lw:   load_data = {{(xlen-32){lane_rdata[31]}}, lane_rdata[31:0]};
            op_lbu:  load_data = {{(xlen-8){1'b0}}, lane_rdata[7:0]};
            op_lhu:  load_data = {{(xlen-16){1'b0}}, lane_rdata[15:0]};
            op_lwu:  load_data = {{(xlen-32){1'b0}}, lane_rdata[31:0]};
            // ld, whole word
            default: load_data = rdata_q;
        endcase
    end

endmodule

`default_nettype wire

//--- source/exu_ctrl.sv
`default_nettype none

module exu_ctrl (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          issue_req,
    output logic                         issue_ack,
    input  wire exu_pkg::exu_op_e        op,
    input  wire [exu_pkg::reg_idx_w-1:0] rd,
    input  wire [exu_pkg::reg_idx_w-1:0] rs1,
    input  wire [exu_pkg::reg_idx_w-1:0] rs2,
    input  wire [exu_pkg::xlen-1:0]      imm,
    input  wire [exu_pkg::xlen-1:0]      pc,
    output logic [exu_pkg::xlen-1:0]     dnpc,
    input  wire [exu_pkg::xlen-1:0]      src1,
    input  wire [exu_pkg::xlen-1:0]      src2,
    output exu_pkg::alu_mode_e           alu_mode,
    output logic [exu_pkg::xlen-1:0]     alu_a,
    output logic [exu_pkg::xlen-1:0]     alu_b,
    input  wire [exu_pkg::xlen-1:0]      alu_result,
    output logic                         lsu_start,
    input  wire                          lsu_done,
    input  wire [exu_pkg::xlen-1:0]      load_data,
    output logic                         wen,
    output logic [exu_pkg::xlen-1:0]     wdata
);
    import exu_pkg::*;

    exu_state_e      state_q;
    logic            is_load;
    logic            is_mem;
    logic            is_branch;
    logic            is_jump;
    logic            is_rtype;
    logic            taken;
    // last cycle of an instruction, ack and writeback on the next edge
    logic            finish;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] next_pc;

    assign is_load   = op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    assign is_mem    = is_load || op inside {op_sb, op_sh, op_sw, op_sd};
    assign is_branch = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    assign is_jump   = op inside {op_jal, op_jalr};
    assign is_rtype  = op inside {op_add, op_sub, op_sll, op_slt, op_sltu,
                                  op_xor, op_srl, op_sra, op_or, op_and};

    // auipc and jal add to pc
    assign alu_a = (op == op_auipc || op == op_jal) ? pc : src1;
    assign alu_b = !(is_rtype || is_branch) ? imm : src2;

    always_comb begin
        case (op)
            op_sub, op_beq, op_bne:               alu_mode = alu_sub;
            op_sll, op_slli:                      alu_mode = alu_sll;
            op_slt, op_slti, op_blt, op_bge:      alu_mode = alu_slt;
            op_sltu, op_sltiu, op_bltu, op_bgeu:  alu_mode = alu_sltu;
            op_xor, op_xori:                      alu_mode = alu_xor;
            op_srl, op_srli:                      alu_mode = alu_srl;
            op_sra, op_srai:                      alu_mode = alu_sra;
            op_or, op_ori:                        alu_mode = alu_or;
            op_and, op_andi:                      alu_mode = alu_and;
            // adds, address and jump targets
            default:                              alu_mode = alu_add;
        endcase
    end

    // branch outcome from the alu compare
    always_comb begin
        case (op)
            op_beq:          taken = alu_result == '0;
            op_bne:          taken = alu_result != '0;
            op_blt, op_bltu: taken = alu_result[0];
            op_bge, op_bgeu: taken = !alu_result[0];
            default:         taken = 1'b0;
        endcase
    end

    assign snpc = pc + xlen'(4);

    always_comb begin
        if (is_jump) begin
            next_pc = {alu_result[xlen-1:1], 1'b0};
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = snpc;
        end
    end

    always_comb begin
        if (op == op_lui) begin
            wdata = imm;
        end else if (is_jump) begin
            wdata = snpc;
        end else if (is_load) begin
            wdata = load_data;
        end else begin
            wdata = alu_result;
        end
    end

    assign lsu_start = issue_req && state_q == st_idle && is_mem;
    assign finish    = issue_req && ((state_q == st_idle && !is_mem) ||
                                     (state_q == st_mem && lsu_done));
    // no writeback for branches, stores or nop
    assign wen = finish && !(is_branch || op == op_nop) &&
                 (is_load || !is_mem);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= st_idle;
            issue_ack <= 1'b0;
            dnpc      <= '0;
        end else if (finish) begin
            state_q   <= st_done;
            issue_ack <= 1'b1;
            dnpc      <= next_pc;
        end else if (lsu_start) begin
            // wait in st_mem for the lsu
            state_q <= st_mem;
        end else if (state_q == st_done && !issue_req) begin
            // host let go, close the handshake
            state_q   <= st_idle;
            issue_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/exu_top.sv
`default_nettype none

module exu_top #(
    parameter int nregs = 32
) (
    input  wire                          clk,
    input  wire                          arst_n,
    // issue port
    input  wire                          issue_req,
    input  wire exu_pkg::exu_op_e        op,
    input  wire [exu_pkg::reg_idx_w-1:0] rd,
    input  wire [exu_pkg::reg_idx_w-1:0] rs1,
    input  wire [exu_pkg::reg_idx_w-1:0] rs2,
    input  wire [exu_pkg::xlen-1:0]      imm,
    input  wire [exu_pkg::xlen-1:0]      pc,
    output logic                         issue_ack,
    output logic [exu_pkg::xlen-1:0]     dnpc,
    // memory port
    output logic                         mem_req,
    output logic                         mem_we,
    output logic [exu_pkg::xlen-1:0]     mem_addr,
    output logic [exu_pkg::xlen-1:0]     mem_wdata,
    output logic [exu_pkg::mask_w-1:0]   mem_wmask,
    input  wire [exu_pkg::xlen-1:0]      mem_rdata,
    input  wire                          mem_ack
);
    import exu_pkg::*;

    // register read data
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    // alu path
    alu_mode_e       alu_mode;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    // lsu and writeback
    logic            lsu_start;
    logic            lsu_done;
    logic [xlen-1:0] load_data;
    logic            wen;
    logic [xlen-1:0] wdata;

    exu_ctrl ctrl0 (.*);

    exu_regfile #(
        .nregs(nregs)
    ) gpr0 (
        .*,
        .raddr_a(rs1),
        .raddr_b(rs2),
        .rdata_a(src1),
        .rdata_b(src2),
        .waddr  (rd)
    );

    exu_alu alu0 (
        .mode  (alu_mode),
        .a     (alu_a),
        .b     (alu_b),
        .result(alu_result)
    );

    // alu result is the effective address, rs2 the store data
    exu_lsu lsu0 (
        .*,
        .start     (lsu_start),
        .addr      (alu_result),
        .store_data(src2)
    );

endmodule

`default_nettype wire

//--- sim/exu_checker.sv
`default_nettype none

module exu_checker (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        issue_ack,
    input  wire [exu_pkg::xlen-1:0]    dnpc,
    input  wire                        mem_req,
    input  wire                        mem_we,
    input  wire                        mem_ack,
    input  wire [exu_pkg::xlen-1:0]    mem_addr,
    input  wire [exu_pkg::xlen-1:0]    mem_wdata,
    input  wire [exu_pkg::mask_w-1:0]  mem_wmask,
    input  int                         test_idx,
    input  wire [exu_pkg::xlen-1:0]    exp_pc,
    input  wire                        chk_st,
    input  wire [exu_pkg::xlen-1:0]    exp_wd,
    input  wire [exu_pkg::mask_w-1:0]  exp_mask,
    input  wire [exu_pkg::xlen-1:0]    exp_addr,
    output int                         errors,
    output int                         tests
);
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    logic              ack_q;
    logic              req_q;
    // last store seen on the memory port
    logic              st_seen;
    logic [xlen-1:0]   st_wd;
    logic [mask_w-1:0] st_mask;
    logic [xlen-1:0]   lanes;
    int                bad;

    // only enabled bytes carry data
    always_comb begin
        for (int i = 0; i < mask_w; i++) begin
            lanes[8*i +: 8] = {8{exp_mask[i]}};
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q   = 1'b0;
            req_q   = 1'b0;
            st_seen = 1'b0;
            st_wd   = '0;
            st_mask = '0;
            bad     = 0;
            errors  = 0;
            tests   = 0;
        end else begin
            // req must wait for the previous ack to drop
            if (mem_req && !req_q && mem_ack) begin
                $display("test %0d: mem_req raised while mem_ack was still high", test_idx);
                bad++;
            end
            // every access goes to the aligned word
            if (mem_req && mem_ack && mem_addr !== exp_addr) begin
                $display("Mismatch test %0d mem_addr: got %h expected %h",
                         test_idx, mem_addr, exp_addr);
                bad++;
            end
            if (mem_req && mem_ack && mem_we) begin
                st_seen = 1'b1;
                st_wd   = mem_wdata;
                st_mask = mem_wmask;
            end
            if (issue_ack && !ack_q) begin
                if (dnpc !== exp_pc) begin
                    $display("Mismatch test %0d dnpc: got %h expected %h", test_idx, dnpc, exp_pc);
                    bad++;
                end
                if (chk_st && !st_seen) begin
                    $display("test %0d: the expected store never reached memory", test_idx);
                    bad++;
                end else if (!chk_st && st_seen) begin
                    $display("test %0d: a store appeared where none was expected", test_idx);
                    bad++;
                end else if (chk_st) begin
                    if (st_mask !== exp_mask) begin
                        $display("Mismatch test %0d mem_wmask: got %h expected %h",
                                 test_idx, st_mask, exp_mask);
                        bad++;
                    end else if ((st_wd & lanes) !== (exp_wd & lanes)) begin
                        $display("Mismatch test %0d mem_wdata: got %h expected %h",
                                 test_idx, st_wd & lanes, exp_wd & lanes);
                        bad++;
                    end
                end
                if (bad == 0) begin
                    $display("test %0d ok", test_idx);
                end else begin
                    $display("test %0d failed with %0d errors", test_idx, bad);
                end
                tests++;
                errors  = errors + bad;
                bad     = 0;
                st_seen = 1'b0;
            end
            ack_q = issue_ack;
            req_q = mem_req;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_exu.sv
`default_nettype none

module tb_exu;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    // one instruction with its expected results
    typedef struct {
        exu_op_e         op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [63:0]     imm;
        logic [63:0]     pc;
        logic [63:0]     exp_pc;
        logic            chk_st;
        logic [63:0]     exp_wd;
        logic [7:0]      exp_mask;
        logic [63:0]     exp_addr;
        logic [63:0]     ld_word;
    } entry_t;

    localparam int max_wait = 200;

    logic                 clk;
    logic                 arst_n;
    logic                 issue_req;
    exu_op_e              op;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      pc;
    logic                 issue_ack;
    logic [xlen-1:0]      dnpc;
    logic                 mem_req;
    logic                 mem_we;
    logic [xlen-1:0]      mem_addr;
    logic [xlen-1:0]      mem_wdata;
    logic [mask_w-1:0]    mem_wmask;
    logic [xlen-1:0]      mem_rdata;
    logic                 mem_ack;
    // expected values handed to the checker
    int                   test_idx;
    logic [xlen-1:0]      exp_pc;
    logic                 chk_st;
    logic [xlen-1:0]      exp_wd;
    logic [mask_w-1:0]    exp_mask;
    logic [xlen-1:0]      exp_addr;
    logic [xlen-1:0]      ld_word;
    int                   errors;
    int                   tests;
    // cleared by a handshake timeout
    logic                 run_ok;
    // memory model state
    int unsigned          delay;
    entry_t               tbl[$];
    logic [63:0]          pc_ctr;
    logic [63:0]          last_pc;

    exu_top #(.nregs(32)) dut0 (.*);

    exu_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ack rises a random number of cycles after req
    // and falls a random number of cycles after req drops
    always @(posedge clk) begin
        if (mem_req && !mem_ack) begin
            if (delay == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= ld_word;
                delay     <= $urandom % 8;
            end else begin
                delay <= delay - 1;
            end
        end else if (!mem_req && mem_ack) begin
            if (delay == 0) begin
                mem_ack <= 1'b0;
                delay   <= $urandom % 5;
            end else begin
                delay <= delay - 1;
            end
        end
    end

    // default entry, falls through to pc+4
    function automatic entry_t mk(exu_op_e o, logic [4:0] d, logic [4:0] s1,
                                  logic [4:0] s2, logic [63:0] im);
        entry_t e;
        e.op       = o;
        e.rd       = d;
        e.rs1      = s1;
        e.rs2      = s2;
        e.imm      = im;
        e.pc       = pc_ctr;
        e.exp_pc   = pc_ctr + 64'd4;
        e.chk_st   = 1'b0;
        e.exp_wd   = '0;
        e.exp_mask = '0;
        e.exp_addr = '0;
        e.ld_word  = '0;
        return e;
    endfunction

    task automatic push(entry_t e);
        tbl.push_back(e);
        last_pc = e.pc;
        pc_ctr  = pc_ctr + 64'd4;
    endtask

    task automatic add_op(exu_op_e o, logic [4:0] d, logic [4:0] s1, logic [4:0] s2,
                          logic [63:0] im);
        push(mk(o, d, s1, s2, im));
    endtask

    // rs1 is x0, so the byte address is the immediate
    task automatic add_st(exu_op_e o, logic [4:0] s2, logic [63:0] im, logic [63:0] wd,
                          logic [7:0] m);
        entry_t e;
        e          = mk(o, 0, 0, s2, im);
        e.chk_st   = 1'b1;
        e.exp_wd   = wd;
        e.exp_mask = m;
        e.exp_addr = im & ~64'h7;
        push(e);
    endtask

    // sd of a register to 0x100, full word
    task automatic add_sd(logic [4:0] s2, logic [63:0] wd);
        add_st(op_sd, s2, 64'h100, wd, 8'hff);
    endtask

    // load from 0x300 plus offset, then store rd back out
    task automatic add_ld(exu_op_e o, int off, logic [63:0] word, logic [63:0] wd);
        entry_t e;
        e          = mk(o, 7, 0, 0, 64'h300 + 64'(off));
        e.ld_word  = word;
        e.exp_addr = 64'h300;
        push(e);
        add_sd(7, wd);
    endtask

    task automatic add_br(exu_op_e o, logic [4:0] s1, logic [4:0] s2, logic [63:0] im,
                          logic tk);
        entry_t e;
        e = mk(o, 0, s1, s2, im);
        if (tk) begin
            e.exp_pc = e.pc + im;
        end
        push(e);
    endtask

    task automatic add_jmp(exu_op_e o, logic [4:0] d, logic [4:0] s1, logic [63:0] im,
                           logic [63:0] target);
        entry_t e;
        e        = mk(o, d, s1, 0, im);
        e.exp_pc = target;
        push(e);
    endtask

    task automatic build_table();
        logic [63:0] w;
        w = 64'hf1e2_d3c4_b5a6_9788;
        // x1 = 0x12345678, x2 = -3, x4 = 4
        add_op(op_lui, 1, 0, 0, 64'h1234_5000);
        add_op(op_addi, 1, 1, 0, 64'h678);
        add_op(op_addi, 2, 0, 0, 64'hffff_ffff_ffff_fffd);
        add_op(op_addi, 4, 0, 0, 64'h4);
        add_op(op_add, 3, 1, 2, 0);
        add_sd(3, 64'h1234_5675);
        add_op(op_sub, 3, 1, 2, 0);
        add_sd(3, 64'h1234_567b);
        add_op(op_sll, 3, 1, 4, 0);
        add_sd(3, 64'h1_2345_6780);
        add_op(op_srl, 3, 2, 4, 0);
        add_sd(3, 64'h0fff_ffff_ffff_ffff);
        add_op(op_sra, 3, 2, 4, 0);
        add_sd(3, 64'hffff_ffff_ffff_ffff);
        add_op(op_slt, 3, 2, 1, 0);
        add_sd(3, 64'h1);
        add_op(op_sltu, 3, 2, 1, 0);
        add_sd(3, 64'h0);
        add_op(op_xor, 3, 1, 2, 0);
        add_sd(3, 64'hffff_ffff_edcb_a985);
        add_op(op_or, 3, 1, 2, 0);
        add_sd(3, 64'hffff_ffff_ffff_fffd);
        add_op(op_and, 3, 1, 2, 0);
        add_sd(3, 64'h1234_5678);
        add_op(op_slli, 3, 1, 0, 64'h8);
        add_sd(3, 64'h12_3456_7800);
        add_op(op_srai, 3, 2, 0, 64'h1);
        add_sd(3, 64'hffff_ffff_ffff_fffe);
        // x0 ignores writes
        add_op(op_addi, 0, 0, 0, 64'h5);
        add_sd(0, 64'h0);
        // taken and not taken, x2 is negative and unsigned huge
        add_br(op_beq, 1, 1, 64'h40, 1'b1);
        add_br(op_beq, 1, 2, 64'h40, 1'b0);
        add_br(op_bne, 1, 2, 64'hffff_ffff_ffff_fff8, 1'b1);
        add_br(op_bne, 1, 1, 64'h40, 1'b0);
        add_br(op_blt, 2, 1, 64'h40, 1'b1);
        add_br(op_blt, 1, 2, 64'h40, 1'b0);
        add_br(op_bge, 1, 2, 64'h80, 1'b1);
        add_br(op_bge, 2, 1, 64'h80, 1'b0);
        add_br(op_bltu, 1, 2, 64'h10, 1'b1);
        add_br(op_bltu, 2, 1, 64'h10, 1'b0);
        add_br(op_bgeu, 2, 1, 64'h20, 1'b1);
        add_br(op_bgeu, 1, 2, 64'h20, 1'b0);
        add_jmp(op_jal, 5, 0, 64'h20, pc_ctr + 64'h20);
        add_sd(5, last_pc + 64'd4);
        // x1 + 5 with bit 0 dropped
        add_jmp(op_jalr, 6, 1, 64'h5, 64'h1234_567c);
        add_sd(6, last_pc + 64'd4);
        for (int k = 0; k < 8; k++) begin
            add_st(op_sb, 1, 64'h200 + 64'(k), 64'h78 << (8 * k), 8'h01 << k);
        end
        for (int k = 0; k < 8; k += 2) begin
            add_st(op_sh, 1, 64'h200 + 64'(k), 64'h5678 << (8 * k), 8'h03 << k);
        end
        for (int k = 0; k < 8; k += 4) begin
            add_st(op_sw, 1, 64'h200 + 64'(k), 64'h1234_5678 << (8 * k), 8'h0f << k);
        end
        add_ld(op_lb, 0, w, 64'hffff_ffff_ffff_ff88);
        add_ld(op_lb, 3, w, 64'hffff_ffff_ffff_ffb5);
        add_ld(op_lbu, 0, w, 64'h88);
        add_ld(op_lbu, 7, w, 64'hf1);
        add_ld(op_lh, 2, w, 64'hffff_ffff_ffff_b5a6);
        add_ld(op_lh, 4, w, 64'hffff_ffff_ffff_d3c4);
        add_ld(op_lhu, 6, w, 64'hf1e2);
        add_ld(op_lw, 0, w, 64'hffff_ffff_b5a6_9788);
        add_ld(op_lw, 4, w, 64'hffff_ffff_f1e2_d3c4);
        add_ld(op_lwu, 4, w, 64'h0000_0000_f1e2_d3c4);
        add_ld(op_ld, 0, w, w);
    endtask

    // one four-phase issue, sampled on the falling edge
    task automatic run_entry(int idx, output logic ok);
        entry_t e;
        int     t;
        e  = tbl[idx];
        ok = 1'b1;
        @(posedge clk);
        op        <= e.op;
        rd        <= e.rd;
        rs1       <= e.rs1;
        rs2       <= e.rs2;
        imm       <= e.imm;
        pc        <= e.pc;
        test_idx  <= idx;
        exp_pc    <= e.exp_pc;
        chk_st    <= e.chk_st;
        exp_wd    <= e.exp_wd;
        exp_mask  <= e.exp_mask;
        exp_addr  <= e.exp_addr;
        ld_word   <= e.ld_word;
        issue_req <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!issue_ack && t < max_wait) begin
            t++;
            @(negedge clk);
        end
        if (!issue_ack) begin
            $display("timeout, issue_ack never rose in test %0d", idx);
            ok = 1'b0;
        end else begin
            @(posedge clk);
            issue_req <= 1'b0;
            t = 0;
            @(negedge clk);
            while (issue_ack && t < max_wait) begin
                t++;
                @(negedge clk);
            end
            if (issue_ack) begin
                $display("timeout, issue_ack never fell in test %0d", idx);
                ok = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha332_134a));
        arst_n    = 1'b0;
        issue_req = 1'b0;
        op        = op_nop;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        pc        = '0;
        mem_rdata = '0;
        mem_ack   = 1'b0;
        test_idx  = 0;
        exp_pc    = '0;
        chk_st    = 1'b0;
        exp_wd    = '0;
        exp_mask  = '0;
        exp_addr  = '0;
        ld_word   = '0;
        run_ok    = 1'b1;
        pc_ctr    = 64'h8000_1000;
        last_pc   = '0;
        build_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < tbl.size() && run_ok; i++) begin
            run_entry(i, run_ok);
        end
        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d errors", tests, errors);
        if (run_ok && errors == 0 && tests == tbl.size()) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/exu_pkg.sv
source/exu_regfile.sv
source/exu_alu.sv
source/exu_lsu.sv
source/exu_ctrl.sv
source/exu_top.sv
sim/exu_checker.sv
sim/tb_exu.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f --top-module tb_exu -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_exu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
